// File: common/desc_fetch_config.svh
// **************************************************
// Descriptor fetch configuration
// Bus widths, speculation depth and request FIFO depth
// **************************************************

`ifndef DESC_FETCH_CONFIG_SVH
`define DESC_FETCH_CONFIG_SVH

// AXI read channel widths
`define DF_DATA_WIDTH 64
`define DF_ADDR_WIDTH 64
`define DF_ID_WIDTH 4

// Descriptors in flight and request FIFO slots
`define DF_N_SPECULATION 4
`define DF_REQ_FIFO_DEPTH 4

`endif

// File: common/axi_ar_pkg.sv
// **************************************************
// AXI read channels
// AR and R payload structs and burst encodings
// **************************************************

`default_nettype none

`include "desc_fetch_config.svh"

package axi_ar_pkg;

    typedef logic [`DF_ID_WIDTH-1:0] axi_id_t;

    typedef struct packed {
        axi_id_t                   id;
        logic [`DF_ADDR_WIDTH-1:0] addr;
        logic [7:0]                len;
        logic [2:0]                size;
        logic [1:0]                burst;
    } axi_ar_chan_t;

    typedef struct packed {
        axi_id_t                   id;
        logic [`DF_DATA_WIDTH-1:0] data;
        logic                      last;
    } axi_r_chan_t;

    localparam logic [1:0] BURST_FIXED = 2'b00;
    localparam logic [1:0] BURST_INCR  = 2'b01;
    localparam logic [1:0] BURST_WRAP  = 2'b10;

endpackage

`default_nettype wire

// File: common/desc_pkg.sv
// **************************************************
// Descriptor types
// Addresses, descriptor layout and request word
// **************************************************

`default_nettype none

`include "desc_fetch_config.svh"

package desc_pkg;

    typedef logic [`DF_ADDR_WIDTH-1:0] addr_t;

    // Memory layout in beats
    // beat 0 {flags, length}, beat 1 next, beat 2 src, beat 3 dst
    typedef struct packed {
        logic [31:0] flags;
        logic [31:0] length;
        addr_t       next;
        addr_t       src;
        addr_t       dst;
    } descriptor_t;

    // Descriptor tagged with the address it was read from
    typedef struct packed {
        addr_t       desc_addr;
        descriptor_t desc;
    } desc_req_t;

    typedef logic [$clog2(`DF_N_SPECULATION + 1)-1:0]  flush_cnt_t;
    typedef logic [$clog2(`DF_REQ_FIFO_DEPTH + 1)-1:0] usage_t;

    // Next pointer that terminates a chain
    localparam addr_t END_OF_CHAIN = '1;

endpackage

`default_nettype wire

// File: rtl/fall_through_fifo.sv
// **************************************************
// Fall-through stream FIFO
// Circular buffer with flush, bypasses when empty
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module fall_through_fifo #(
    parameter int unsigned DEPTH = 4,
    parameter type         T     = logic
) (
    input  logic                       clk_i,
    input  logic                       reset_i,
    input  logic                       flush_i,
    output logic [$clog2(DEPTH+1)-1:0] usage_o,
    input  T                           data_i,
    input  logic                       valid_i,
    output logic                       ready_o,
    output T                           data_o,
    output logic                       valid_o,
    input  logic                       ready_i
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    T                 mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             empty;
    logic             push;
    logic             pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty   = (count_q == '0);
    assign ready_o = (count_q < DEPTH);
    assign valid_o = !empty || valid_i;
    assign data_o  = empty ? data_i : mem_q[rd_ptr_q];
    assign usage_o = count_q;

    // Word is only stored when it cannot pass straight through
    assign push = valid_i && ready_o && !(empty && ready_i);
    assign pop  = !empty && ready_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: desc_prefetch/desc_ar_gen_prefetch.sv
// **************************************************
// Descriptor AR generator
// Prefetches descriptors at consecutive addresses
// and flushes when a next pointer breaks the guess
// **************************************************

`timescale 1ns/1ps
`default_nettype none

`include "desc_fetch_config.svh"

module desc_ar_gen_prefetch (
    input  logic                     clk_i,
    input  logic                     reset_i,
    output axi_ar_pkg::axi_ar_chan_t ar_o,
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    input  axi_ar_pkg::axi_id_t      ar_id_i,
    input  desc_pkg::addr_t          queued_addr_i,
    input  logic                     queued_addr_valid_i,
    output logic                     queued_addr_ready_o,
    input  desc_pkg::addr_t          next_addr_i,
    input  logic                     next_addr_valid_i,
    input  desc_pkg::usage_t         req_free_slots_i,
    output desc_pkg::flush_cnt_t     n_flush_o,
    output logic                     n_flush_valid_o,
    output desc_pkg::addr_t          feedback_addr_o,
    output logic                     feedback_addr_valid_o,
    output logic                     busy_o
);

    import axi_ar_pkg::*;
    import desc_pkg::*;

    localparam int unsigned DESC_BYTES = $bits(descriptor_t) / 8;
    localparam int unsigned BEAT_BYTES = `DF_DATA_WIDTH / 8;
    localparam logic [7:0]  AR_LEN     = 8'(DESC_BYTES / BEAT_BYTES - 1);
    localparam logic [2:0]  AR_SIZE    = 3'($clog2(BEAT_BYTES));

    typedef struct packed {
        logic  speculative;
        addr_t addr;
    } pending_ar_t;

    addr_t       base_addr_q;
    logic        base_valid_q;
    flush_cnt_t  inflight_q;
    logic        next_valid_q;
    logic        next_strobe;
    logic        end_of_chain;
    logic        take_queued;
    pending_ar_t next_ar;
    logic        next_ar_valid;
    logic        next_ar_ready;
    pending_ar_t staging;
    logic        pend_valid;
    logic        pend_ready;
    logic        leg_valid;
    logic        leg_ready;
    logic        spec_push;
    logic        spec_ready;
    logic        spec_valid;
    addr_t       spec_addr;
    flush_cnt_t  spec_usage;
    addr_t       ar_addr;
    logic        spec_hit;
    logic        commit;
    logic        flush;
    logic        fb_direct;

    assign end_of_chain = (next_addr_i == END_OF_CHAIN);
    assign next_strobe  = next_addr_valid_i && !next_valid_q;

    // Limited by speculation depth and by free request FIFO slots
    assign next_ar_valid = base_valid_q && (inflight_q < `DF_N_SPECULATION) &&
                           (req_free_slots_i > inflight_q);
    assign next_ar.speculative = (inflight_q != '0);
    assign next_ar.addr        = base_addr_q + (addr_t'(inflight_q) << $clog2(DESC_BYTES));

    // Speculative addresses leave only when they can be recorded as well
    assign leg_valid  = pend_valid && (spec_ready || !staging.speculative) && !flush;
    assign pend_ready = leg_ready && (spec_ready || !staging.speculative) && !flush;
    assign spec_push  = pend_valid && leg_ready && staging.speculative;

    // Guess must match the next pointer, or the queued start at chain end
    assign spec_hit = spec_valid &&
        (end_of_chain ? (queued_addr_valid_i && spec_addr == queued_addr_i)
                      : (spec_addr == next_addr_i));
    assign commit = next_strobe && spec_hit;
    assign flush  = next_strobe && !spec_hit;

    // Start address taken when idle or when the current chain just ended
    assign queued_addr_ready_o = !base_valid_q || (next_strobe && end_of_chain);
    assign take_queued         = queued_addr_valid_i && queued_addr_ready_o;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            base_valid_q <= 1'b0;
            inflight_q   <= '0;
            next_valid_q <= 1'b0;
        end else begin
            next_valid_q <= next_addr_valid_i;
            if (flush) begin
                inflight_q <= '0;
            end else begin
                inflight_q <= inflight_q + flush_cnt_t'(next_ar_valid && next_ar_ready)
                              - flush_cnt_t'(commit);
            end
            if (take_queued) begin
                base_valid_q <= 1'b1;
            end else if (next_strobe && end_of_chain) begin
                base_valid_q <= 1'b0;
            end
        end
    end

    // Rebase on every returned pointer, the queued start at chain end
    always_ff @(posedge clk_i) begin
        if (next_strobe && !end_of_chain) begin
            base_addr_q <= next_addr_i;
        end else if (take_queued) begin
            base_addr_q <= queued_addr_i;
        end
    end

    // First address after a rebase is certain and skips the speculation queue
    assign fb_direct             = leg_valid && leg_ready && !staging.speculative;
    assign feedback_addr_o       = fb_direct ? staging.addr : spec_addr;
    assign feedback_addr_valid_o = fb_direct || commit;

    fall_through_fifo #(
        .DEPTH(`DF_N_SPECULATION),
        .T    (pending_ar_t)
    ) i_pending_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .flush_i(flush),
        .usage_o(),
        .data_i (next_ar),
        .valid_i(next_ar_valid),
        .ready_o(next_ar_ready),
        .data_o (staging),
        .valid_o(pend_valid),
        .ready_i(pend_ready)
    );

    // Addresses issued on a guess, oldest first
    fall_through_fifo #(
        .DEPTH(`DF_N_SPECULATION),
        .T    (addr_t)
    ) i_speculation_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .flush_i(flush),
        .usage_o(spec_usage),
        .data_i (staging.addr),
        .valid_i(spec_push),
        .ready_o(spec_ready),
        .data_o (spec_addr),
        .valid_o(spec_valid),
        .ready_i(commit)
    );

    // Holds AR stable until accepted, never flushed
    fall_through_fifo #(
        .DEPTH(1),
        .T    (addr_t)
    ) i_legalization_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .flush_i(1'b0),
        .usage_o(),
        .data_i (staging.addr),
        .valid_i(leg_valid),
        .ready_o(leg_ready),
        .data_o (ar_addr),
        .valid_o(ar_valid_o),
        .ready_i(ar_ready_i)
    );

    assign n_flush_o       = spec_usage;
    assign n_flush_valid_o = flush;
    assign busy_o          = base_valid_q || (inflight_q != '0);

    assign ar_o = '{
        id:    ar_id_i,
        addr:  ar_addr,
        len:   AR_LEN,
        size:  AR_SIZE,
        burst: BURST_INCR
    };

endmodule

`default_nettype wire

// File: desc_prefetch/desc_r_collector.sv
// **************************************************
// Descriptor R collector
// Builds descriptors from R beats, drops flushed ones
// and tags kept ones with their fetch address
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module desc_r_collector (
    input  logic                    clk_i,
    input  logic                    reset_i,
    input  axi_ar_pkg::axi_r_chan_t r_i,
    input  logic                    r_valid_i,
    output logic                    r_ready_o,
    input  desc_pkg::flush_cnt_t    n_flush_i,
    input  logic                    n_flush_valid_i,
    input  desc_pkg::addr_t         feedback_addr_i,
    input  logic                    feedback_addr_valid_i,
    output desc_pkg::addr_t         next_addr_o,
    output logic                    next_addr_valid_o,
    output desc_pkg::desc_req_t     req_o,
    output logic                    req_valid_o
);

    import desc_pkg::*;

    logic        r_ready_q;
    logic [1:0]  beat_q;
    descriptor_t desc_q;
    flush_cnt_t  discard_q;
    addr_t       fb_q [2];
    logic [1:0]  fb_cnt_q;
    desc_req_t   req_q;
    logic        req_valid_q;
    logic        beat_fire;
    logic        last_fire;
    logic        keep_last;

    assign r_ready_o = r_ready_q;
    assign beat_fire = r_valid_i && r_ready_q;
    assign last_fire = beat_fire && r_i.last;
    assign keep_last = last_fire && (discard_q == '0);

    // Pointer of a kept descriptor goes back to the generator at its last beat
    assign next_addr_o       = desc_q.next;
    assign next_addr_valid_o = keep_last;

    assign req_o       = req_q;
    assign req_valid_o = req_valid_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            r_ready_q   <= 1'b0;
            beat_q      <= '0;
            discard_q   <= '0;
            fb_cnt_q    <= '0;
            req_valid_q <= 1'b0;
        end else begin
            r_ready_q   <= 1'b1;
            req_valid_q <= keep_last;
            if (beat_fire) begin
                beat_q <= r_i.last ? 2'd0 : beat_q + 2'd1;
            end
            // A flush lands only on a kept descriptor, so the count is idle then
            if (n_flush_valid_i) begin
                discard_q <= n_flush_i;
            end else if (last_fire && discard_q != '0) begin
                discard_q <= discard_q - 1'b1;
            end
            case ({feedback_addr_valid_i, keep_last})
                2'b10:   fb_cnt_q <= fb_cnt_q + 2'd1;
                2'b01:   fb_cnt_q <= fb_cnt_q - 2'd1;
                default: fb_cnt_q <= fb_cnt_q;
            endcase
        end
    end

    // Beat order follows the descriptor layout
    always_ff @(posedge clk_i) begin
        if (beat_fire) begin
            case (beat_q)
                2'd0:    {desc_q.flags, desc_q.length} <= r_i.data;
                2'd1:    desc_q.next <= r_i.data;
                2'd2:    desc_q.src <= r_i.data;
                default: desc_q.dst <= r_i.data;
            endcase
        end
    end

    // Feedback address queue, oldest in slot 0
    always_ff @(posedge clk_i) begin
        if (feedback_addr_valid_i && keep_last) begin
            if (fb_cnt_q == 2'd1) begin
                fb_q[0] <= feedback_addr_i;
            end else begin
                fb_q[0] <= fb_q[1];
                fb_q[1] <= feedback_addr_i;
            end
        end else if (feedback_addr_valid_i) begin
            fb_q[fb_cnt_q[0]] <= feedback_addr_i;
        end else if (keep_last) begin
            fb_q[0] <= fb_q[1];
        end
    end

    always_ff @(posedge clk_i) begin
        if (keep_last) begin
            req_q.desc_addr <= fb_q[0];
            req_q.desc      <= desc_q;
            req_q.desc.dst  <= r_i.data;
        end
    end

endmodule

`default_nettype wire

// File: rtl/desc_fetch_top.sv
// **************************************************
// Descriptor fetch frontend
// AR generator, R collector and request FIFO
// **************************************************

`timescale 1ns/1ps
`default_nettype none

`include "desc_fetch_config.svh"

module desc_fetch_top (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  axi_ar_pkg::axi_id_t      ar_id_i,
    input  desc_pkg::addr_t          queued_addr_i,
    input  logic                     queued_addr_valid_i,
    output logic                     queued_addr_ready_o,
    output axi_ar_pkg::axi_ar_chan_t ar_o,
    output logic                     ar_valid_o,
    input  logic                     ar_ready_i,
    input  axi_ar_pkg::axi_r_chan_t  r_i,
    input  logic                     r_valid_i,
    output logic                     r_ready_o,
    output desc_pkg::desc_req_t      req_o,
    output logic                     req_valid_o,
    input  logic                     req_ready_i,
    output logic                     busy_o
);

    import desc_pkg::*;

    addr_t      next_addr;
    logic       next_addr_valid;
    addr_t      feedback_addr;
    logic       feedback_addr_valid;
    flush_cnt_t n_flush;
    logic       n_flush_valid;
    logic       gen_busy;
    desc_req_t  coll_req;
    logic       coll_req_valid;
    usage_t     req_usage;
    usage_t     req_free;

    // A descriptor in the collector output register already owns a slot
    assign req_free = usage_t'(`DF_REQ_FIFO_DEPTH) - req_usage - usage_t'(coll_req_valid);

    assign busy_o = gen_busy || req_valid_o;

    desc_ar_gen_prefetch i_ar_gen (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .ar_o                 (ar_o),
        .ar_valid_o           (ar_valid_o),
        .ar_ready_i           (ar_ready_i),
        .ar_id_i              (ar_id_i),
        .queued_addr_i        (queued_addr_i),
        .queued_addr_valid_i  (queued_addr_valid_i),
        .queued_addr_ready_o  (queued_addr_ready_o),
        .next_addr_i          (next_addr),
        .next_addr_valid_i    (next_addr_valid),
        .req_free_slots_i     (req_free),
        .n_flush_o            (n_flush),
        .n_flush_valid_o      (n_flush_valid),
        .feedback_addr_o      (feedback_addr),
        .feedback_addr_valid_o(feedback_addr_valid),
        .busy_o               (gen_busy)
    );

    desc_r_collector i_r_collector (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .r_i                  (r_i),
        .r_valid_i            (r_valid_i),
        .r_ready_o            (r_ready_o),
        .n_flush_i            (n_flush),
        .n_flush_valid_i      (n_flush_valid),
        .feedback_addr_i      (feedback_addr),
        .feedback_addr_valid_i(feedback_addr_valid),
        .next_addr_o          (next_addr),
        .next_addr_valid_o    (next_addr_valid),
        .req_o                (coll_req),
        .req_valid_o          (coll_req_valid)
    );

    // Never full when written, the generator reserves a slot per fetch
    fall_through_fifo #(
        .DEPTH(`DF_REQ_FIFO_DEPTH),
        .T    (desc_req_t)
    ) i_req_fifo (
        .clk_i  (clk_i),
        .reset_i(reset_i),
        .flush_i(1'b0),
        .usage_o(req_usage),
        .data_i (coll_req),
        .valid_i(coll_req_valid),
        .ready_o(),
        .data_o (req_o),
        .valid_o(req_valid_o),
        .ready_i(req_ready_i)
    );

endmodule

`default_nettype wire

// File: dv/desc_fetch_properties.sv
// **************************************************
// Descriptor fetch assertions
// AR stability, R acceptance, request FIFO bound
// and quiet outputs in reset
// **************************************************

`timescale 1ns/1ps
`default_nettype none

`include "desc_fetch_config.svh"

module desc_fetch_properties (
    input logic                     clk_i,
    input logic                     reset_i,
    input axi_ar_pkg::axi_ar_chan_t ar_i,
    input logic                     ar_valid_i,
    input logic                     ar_ready_i,
    input logic                     r_valid_i,
    input logic                     r_ready_i,
    input logic                     req_valid_i,
    input logic                     busy_i,
    input desc_pkg::usage_t         req_usage_i,
    input logic                     fifo_write_i
);

    int unsigned assert_errors = 0;

    // AR payload holds until the slave takes it
    ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else begin
            $error("AR request dropped or changed before it was accepted");
            assert_errors++;
        end

    r_accept: assert property (@(posedge clk_i) disable iff (reset_i)
        r_valid_i |-> r_ready_i)
        else begin
            $error("R beat offered while the collector was not ready");
            assert_errors++;
        end

    // Collector writes only into a slot that is still free
    req_no_overflow: assert property (@(posedge clk_i) disable iff (reset_i)
        fifo_write_i |-> req_usage_i < `DF_REQ_FIFO_DEPTH)
        else begin
            $error("Request FIFO written while full");
            assert_errors++;
        end

    reset_quiet: assert property (@(posedge clk_i)
        reset_i |=> !ar_valid_i && !req_valid_i && !busy_i)
        else begin
            $error("Outputs active while reset was applied");
            assert_errors++;
        end

endmodule

`default_nettype wire

// File: dv/desc_fetch_checker.sv
// **************************************************
// Descriptor fetch checker
// Walks the model chains and compares requests and
// AR requests with the expected values
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module desc_fetch_checker (
    input  logic                     clk_i,
    input  logic                     reset_i,
    input  axi_ar_pkg::axi_id_t      ar_id_i,
    input  axi_ar_pkg::axi_ar_chan_t ar_i,
    input  logic                     ar_valid_i,
    input  logic                     ar_ready_i,
    input  desc_pkg::desc_req_t      req_i,
    input  logic                     req_valid_i,
    input  logic                     req_ready_i,
    input  logic                     busy_i,
    output logic                     done_o
);

    import axi_ar_pkg::*;
    import desc_pkg::*;

    desc_req_t   expected [$];
    int unsigned expected_total  = 0;
    int unsigned received        = 0;
    int unsigned mismatch_errors = 0;
    int unsigned other_errors    = 0;

    assign done_o = (expected_total != 0) && (received == expected_total);

    task automatic note_failure(input string what);
        other_errors++;
        $display("Error: %s", what);
    endtask

    task automatic compare(input string test, input logic [255:0] want,
                           input logic [255:0] got);
        if (want !== got) begin
            mismatch_errors++;
            $display("Mismatch in %s: expected %0h, actual %0h", test, want, got);
        end
    endtask

    // Follow next pointers from the start until the end marker
    task automatic walk_chain(input addr_t start);
        addr_t     addr;
        desc_req_t item;
        addr = start;
        while (addr != END_OF_CHAIN) begin
            if (!desc_fetch_tb.mem.exists(addr)) begin
                note_failure("chain points outside the memory model");
                return;
            end
            item.desc_addr = addr;
            item.desc      = desc_fetch_tb.mem[addr];
            expected.push_back(item);
            expected_total++;
            addr = item.desc.next;
        end
    endtask

    always @(negedge clk_i) begin
        desc_req_t want;
        if (reset_i) begin
            if (ar_valid_i || req_valid_i || busy_i) begin
                note_failure("outputs active during reset");
            end
        end else begin
            if (ar_valid_i && ar_ready_i) begin
                compare("ar_format len", 3, ar_i.len);
                compare("ar_format size", 3, ar_i.size);
                compare("ar_format burst", BURST_INCR, ar_i.burst);
                compare("ar_format id", ar_id_i, ar_i.id);
                compare("ar_format alignment", 0, ar_i.addr[4:0]);
            end
            if (req_valid_i && req_ready_i) begin
                if (expected.size() == 0) begin
                    note_failure("request arrived after every chain was complete");
                end else begin
                    want = expected.pop_front();
                    received++;
                    compare("chain_order", want.desc, req_i.desc);
                    compare("address_tag", want.desc_addr, req_i.desc_addr);
                end
            end
        end
    end

    task automatic report();
        if (expected.size() != 0) begin
            note_failure($sformatf("%0d expected requests never arrived", expected.size()));
        end
        $display("Checked %0d of %0d requests, errors: %0d mismatch, %0d other, %0d assertion",
                 received, expected_total, mismatch_errors, other_errors,
                 desc_fetch_tb.UUT.u_props.assert_errors);
    endtask

    function automatic int unsigned error_total();
        return mismatch_errors + other_errors + desc_fetch_tb.UUT.u_props.assert_errors;
    endfunction

endmodule

`default_nettype wire

// File: dv/desc_fetch_tb.sv
// **************************************************
// Descriptor fetch testbench
// AXI memory model with random chains, start address
// driver, random back-pressure and watchdog
// **************************************************

`timescale 1ns/1ps
`default_nettype none

module desc_fetch_tb;

    import axi_ar_pkg::*;
    import desc_pkg::*;

    localparam int unsigned N_DESC         = 40;
    localparam int unsigned TIMEOUT_CYCLES = N_DESC * 200;

    logic         clk;
    logic         reset;
    axi_id_t      ar_id;
    addr_t        queued_addr;
    logic         queued_addr_valid;
    logic         queued_addr_ready;
    axi_ar_chan_t ar;
    logic         ar_valid;
    logic         ar_ready;
    axi_r_chan_t  r;
    logic         r_valid;
    logic         r_ready;
    desc_req_t    req;
    logic         req_valid;
    logic         req_ready;
    logic         busy;
    logic         checker_done;

    // Sparse descriptor memory and the chains stored in it
    descriptor_t  mem [addr_t];
    addr_t        chain_starts [$];
    int unsigned  chain_gaps [$];
    addr_t        ar_queue [$];
    integer       seed = 3;

    desc_fetch_top UUT (
        .clk_i              (clk),
        .reset_i            (reset),
        .ar_id_i            (ar_id),
        .queued_addr_i      (queued_addr),
        .queued_addr_valid_i(queued_addr_valid),
        .queued_addr_ready_o(queued_addr_ready),
        .ar_o               (ar),
        .ar_valid_o         (ar_valid),
        .ar_ready_i         (ar_ready),
        .r_i                (r),
        .r_valid_i          (r_valid),
        .r_ready_o          (r_ready),
        .req_o              (req),
        .req_valid_o        (req_valid),
        .req_ready_i        (req_ready),
        .busy_o             (busy)
    );

    desc_fetch_checker u_checker (
        .clk_i      (clk),
        .reset_i    (reset),
        .ar_id_i    (ar_id),
        .ar_i       (ar),
        .ar_valid_i (ar_valid),
        .ar_ready_i (ar_ready),
        .req_i      (req),
        .req_valid_i(req_valid),
        .req_ready_i(req_ready),
        .busy_i     (busy),
        .done_o     (checker_done)
    );

    bind desc_fetch_top desc_fetch_properties u_props (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .ar_i        (ar_o),
        .ar_valid_i  (ar_valid_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_ready_i   (r_ready_o),
        .req_valid_i (req_valid_o),
        .busy_i      (busy_o),
        .req_usage_i (req_usage),
        .fifo_write_i(coll_req_valid)
    );

    // Chains in separate regions, mostly sequential with random jumps forward
    task automatic build_memory();
        addr_t       addr;
        addr_t       next;
        int unsigned left;
        int unsigned len;
        int unsigned chain;
        left  = N_DESC;
        chain = 0;
        while (left != 0) begin
            len = 2 + $unsigned($random(seed)) % 10;
            if (len > left) begin
                len = left;
            end
            addr = 64'h0000_0040_0000_0000 + (addr_t'(chain) << 20) +
                   (addr_t'($unsigned($random(seed)) % 64) << 5);
            chain_starts.push_back(addr);
            chain_gaps.push_back($unsigned($random(seed)) % 4);
            for (int i = 0; i < len; i++) begin
                if (i == len - 1) begin
                    next = END_OF_CHAIN;
                end else if ($unsigned($random(seed)) % 4 == 0) begin
                    next = addr + (addr_t'(2 + $unsigned($random(seed)) % 8) << 5);
                end else begin
                    next = addr + 32;
                end
                mem[addr].flags  = $random(seed);
                mem[addr].length = $random(seed);
                mem[addr].next   = next;
                mem[addr].src    = {$random(seed), $random(seed)};
                mem[addr].dst    = {$random(seed), $random(seed)};
                addr = next;
            end
            left  = left - len;
            chain = chain + 1;
        end
    endtask

    // Addresses without a descriptor read back a pattern of the address
    function automatic logic [63:0] beat_data(input addr_t addr, input int beat);
        descriptor_t d;
        if (!mem.exists(addr)) begin
            return {addr[31:0], addr[63:32]} ^ (64'h5A5A_0000_0000_0000 | 64'(beat));
        end
        d = mem[addr];
        case (beat)
            0:       return {d.flags, d.length};
            1:       return d.next;
            2:       return d.src;
            default: return d.dst;
        endcase
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        ar_ready  = 1'b0;
        req_ready = 1'b0;
        forever begin
            @(posedge clk);
            #10;
            ar_ready  = ($unsigned($random(seed)) % 4) != 0;
            req_ready = ($unsigned($random(seed)) % 3) != 0;
        end
    end

    always @(negedge clk) begin
        if (!reset && ar_valid && ar_ready) begin
            ar_queue.push_back(ar.addr);
        end
    end

    // In-order R responder, four beats per AR after a random delay
    initial begin
        addr_t       addr;
        int unsigned delay;
        r       = '0;
        r_valid = 1'b0;
        forever begin
            @(posedge clk);
            if (!reset && ar_queue.size() != 0) begin
                addr  = ar_queue.pop_front();
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                for (int beat = 0; beat < 4; beat++) begin
                    #10;
                    r.id    = ar_id;
                    r.data  = beat_data(addr, beat);
                    r.last  = (beat == 3);
                    r_valid = 1'b1;
                    do @(negedge clk); while (!r_ready);
                    @(posedge clk);
                end
                #10;
                r_valid = 1'b0;
            end
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Error: watchdog expired after %0d cycles, DUT hung", TIMEOUT_CYCLES);
        u_checker.report();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        int unsigned drain;
        reset             = 1'b1;
        queued_addr       = '0;
        queued_addr_valid = 1'b0;
        ar_id             = axi_id_t'($random(seed));
        build_memory();
        foreach (chain_starts[i]) begin
            u_checker.walk_chain(chain_starts[i]);
        end
        repeat (2) @(posedge clk);
        #10;
        reset = 1'b0;

        // Hand in each chain start and wait for it to be taken
        foreach (chain_starts[i]) begin
            queued_addr       = chain_starts[i];
            queued_addr_valid = 1'b1;
            do @(negedge clk); while (!queued_addr_ready);
            @(posedge clk);
            #10;
            queued_addr_valid = 1'b0;
            repeat (chain_gaps[i]) begin
                @(posedge clk);
                #10;
            end
        end

        do @(negedge clk); while (!checker_done);
        for (drain = 0; drain < 200; drain++) begin
            @(negedge clk);
            if (!busy && !ar_valid && !r_valid && ar_queue.size() == 0) begin
                break;
            end
        end
        if (drain == 200) begin
            u_checker.note_failure("DUT did not return to idle after the final request");
        end
        repeat (10) begin
            @(negedge clk);
            if (busy || ar_valid || req_valid) begin
                u_checker.note_failure("DUT left idle after the final request");
            end
        end

        u_checker.report();
        if (u_checker.error_total() == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+common
common/axi_ar_pkg.sv
common/desc_pkg.sv
rtl/fall_through_fifo.sv
desc_prefetch/desc_ar_gen_prefetch.sv
desc_prefetch/desc_r_collector.sv
rtl/desc_fetch_top.sv
dv/desc_fetch_properties.sv
dv/desc_fetch_checker.sv
dv/desc_fetch_tb.sv

// File: Bender.yml
package:
  name: desc_fetch

export_include_dirs:
  - common

sources:
  - common/axi_ar_pkg.sv
  - common/desc_pkg.sv
  - rtl/fall_through_fifo.sv
  - desc_prefetch/desc_ar_gen_prefetch.sv
  - desc_prefetch/desc_r_collector.sv
  - rtl/desc_fetch_top.sv
  - target: test
    files:
      - dv/desc_fetch_properties.sv
      - dv/desc_fetch_checker.sv
      - dv/desc_fetch_tb.sv
